//--- hdl/xbar_pkg.sv
package xbar_pkg;

	// bus widths
	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;
	localparam int PROT_W = 3;
	localparam int RESP_W = 2;

	// crossbar shape
	localparam int NUM_MASTERS = 2;
	localparam int NUM_SLAVES  = 2;
	localparam int SLV_IDX_W   = 1;
	localparam int MST_IDX_W   = 1;

	// window select bits of the address
	localparam int MAP_SEL_HI = 31;
	localparam int MAP_SEL_LO = 30;
	localparam int MAP_SEL_W  = MAP_SEL_HI - MAP_SEL_LO + 1;

	// slave 0 at 00, slave 1 at 01, the rest unmapped
	localparam logic [NUM_SLAVES-1:0][MAP_SEL_W-1:0] SLV_BASE_SEL = {2'b01, 2'b00};

	// outstanding reads per master, full at all ones
	localparam int PEND_W = 5;

	typedef enum logic [RESP_W-1:0] {
		RESP_OKAY   = 2'b00,
		RESP_SLVERR = 2'b10,
		RESP_DECERR = 2'b11
	} resp_e;

	// what a master currently owns
	typedef enum logic [1:0] {
		GRANT_NONE  = 2'd0,
		GRANT_SLAVE = 2'd1,
		GRANT_ERROR = 2'd2
	} grant_e;

endpackage

//--- hdl/rd_req_if.sv
interface rd_req_if;
	import xbar_pkg::*;

	// held request from the decoder
	logic                 valid;
	logic [ADDR_W-1:0]    addr;
	logic [PROT_W-1:0]    prot;
	logic                 is_err;
	logic [SLV_IDX_W-1:0] slv_idx;

	// one-cycle take of the held request
	logic accept;

	// pending state from the return path
	logic idle;
	logic full;

	modport source (
		output valid, addr, prot, is_err, slv_idx,
		input  accept
	);

	modport arbiter (
		input  valid, addr, prot, is_err, slv_idx, idle, full,
		output accept
	);

	modport monitor (
		input  valid, is_err, accept,
		output idle, full
	);

endinterface

//--- hdl/rd_addr_decode.sv
module rd_addr_decode (
	input  logic                        S_AXI_ACLK,
	input  logic                        S_AXI_ARESETN,
	input  logic                        i_s_arvalid,
	output logic                        o_s_arready,
	input  logic [xbar_pkg::ADDR_W-1:0] i_s_araddr,
	input  logic [xbar_pkg::PROT_W-1:0] i_s_arprot,
	rd_req_if.source                    req
);
	import xbar_pkg::*;

	logic                 hold_valid;
	logic [ADDR_W-1:0]    hold_addr;
	logic [PROT_W-1:0]    hold_prot;
	logic                 hold_err;
	logic [SLV_IDX_W-1:0] hold_idx;
	logic                 dec_err;
	logic [SLV_IDX_W-1:0] dec_idx;
	logic                 capture;

	// register frees on accept, so back-to-back capture works
	assign o_s_arready = !hold_valid || req.accept;
	assign capture     = i_s_arvalid && o_s_arready;

	// window lookup on the incoming address
	always_comb
	begin
		dec_err = 1'b1;
		dec_idx = '0;
		for (int s = 0; s < NUM_SLAVES; s++)
		begin
			if (i_s_araddr[MAP_SEL_HI:MAP_SEL_LO] == SLV_BASE_SEL[s])
			begin
				dec_err = 1'b0;
				dec_idx = SLV_IDX_W'(s);
			end
		end
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			hold_valid <= 1'b0;
		else if (capture)
			hold_valid <= 1'b1;
		else if (req.accept)
			hold_valid <= 1'b0;
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (capture)
		begin
			hold_addr <= i_s_araddr;
			hold_prot <= i_s_arprot;
			hold_err  <= dec_err;
			hold_idx  <= dec_idx;
		end
	end

	assign req.valid   = hold_valid;
	assign req.addr    = hold_addr;
	assign req.prot    = hold_prot;
	assign req.is_err  = hold_err;
	assign req.slv_idx = hold_idx;

endmodule

//--- hdl/rd_grant_arbiter.sv
module rd_grant_arbiter (
	input  logic                                                  S_AXI_ACLK,
	input  logic                                                  S_AXI_ARESETN,
	input  logic [xbar_pkg::NUM_SLAVES-1:0]                       i_m_arready,
	input  logic [xbar_pkg::NUM_MASTERS-1:0]                      i_r_take,
	output logic [xbar_pkg::NUM_SLAVES-1:0]                       o_m_arvalid,
	output logic [xbar_pkg::NUM_SLAVES-1:0][xbar_pkg::ADDR_W-1:0] o_m_araddr,
	output logic [xbar_pkg::NUM_SLAVES-1:0][xbar_pkg::PROT_W-1:0] o_m_arprot,
	output logic [xbar_pkg::NUM_SLAVES-1:0]                       o_m_rready,
	output xbar_pkg::grant_e                   o_grant [xbar_pkg::NUM_MASTERS],
	output logic [xbar_pkg::NUM_MASTERS-1:0][xbar_pkg::SLV_IDX_W-1:0] o_grant_idx,
	rd_req_if.arbiter                          req [xbar_pkg::NUM_MASTERS]
);
	import xbar_pkg::*;

	logic [NUM_MASTERS-1:0]                m_valid;
	logic [NUM_MASTERS-1:0]                m_is_err;
	logic [NUM_MASTERS-1:0]                m_idle;
	logic [NUM_MASTERS-1:0]                m_full;
	logic [NUM_MASTERS-1:0]                m_accept;
	logic [NUM_MASTERS-1:0][ADDR_W-1:0]    m_addr;
	logic [NUM_MASTERS-1:0][PROT_W-1:0]    m_prot;
	logic [NUM_MASTERS-1:0][SLV_IDX_W-1:0] m_slv;

	grant_e                                grant_q [NUM_MASTERS];
	logic [NUM_MASTERS-1:0][SLV_IDX_W-1:0] grant_idx_q;
	logic [NUM_MASTERS-1:0]                on_target;
	logic [NUM_MASTERS-1:0]                do_switch;
	logic [NUM_MASTERS-1:0]                do_drop;

	logic [NUM_SLAVES-1:0]                 slv_owned;
	logic [NUM_SLAVES-1:0][MST_IDX_W-1:0]  slv_owner;
	logic [NUM_SLAVES-1:0]                 slv_wanted;
	logic [NUM_SLAVES-1:0]                 slv_claimed;
	logic [NUM_SLAVES-1:0]                 slv_load;

	// flatten the interface array
	for (genvar g = 0; g < NUM_MASTERS; g++)
	begin : g_req
		assign m_valid[g]     = req[g].valid;
		assign m_is_err[g]    = req[g].is_err;
		assign m_idle[g]      = req[g].idle;
		assign m_full[g]      = req[g].full;
		assign m_addr[g]      = req[g].addr;
		assign m_prot[g]      = req[g].prot;
		assign m_slv[g]       = req[g].slv_idx;
		assign req[g].accept  = m_accept[g];
		assign o_grant[g]     = grant_q[g];
	end

	assign o_grant_idx = grant_idx_q;

	always_comb
	begin
		for (int m = 0; m < NUM_MASTERS; m++)
		begin
			if (m_is_err[m])
				on_target[m] = (grant_q[m] == GRANT_ERROR);
			else
				on_target[m] = (grant_q[m] == GRANT_SLAVE) && (grant_idx_q[m] == m_slv[m]);
		end
	end

	// owner table, plus slaves asked for by a non-owner
	always_comb
	begin
		slv_owned  = '0;
		slv_owner  = '0;
		slv_wanted = '0;
		for (int m = 0; m < NUM_MASTERS; m++)
		begin
			if (grant_q[m] == GRANT_SLAVE)
			begin
				slv_owned[grant_idx_q[m]] = 1'b1;
				slv_owner[grant_idx_q[m]] = MST_IDX_W'(m);
			end
			if (m_valid[m] && !m_is_err[m] && !on_target[m])
				slv_wanted[m_slv[m]] = 1'b1;
		end
	end

	// lower index claims a free slave first
	always_comb
	begin
		slv_claimed = '0;
		do_switch   = '0;
		do_drop     = '0;
		for (int m = 0; m < NUM_MASTERS; m++)
		begin
			if (m_valid[m] && m_idle[m] && !on_target[m])
			begin
				if (m_is_err[m])
					do_switch[m] = 1'b1;
				else if (!slv_owned[m_slv[m]] && !slv_claimed[m_slv[m]])
				begin
					do_switch[m]           = 1'b1;
					slv_claimed[m_slv[m]] = 1'b1;
				end
			end
			// idle owner gives its slave up to the other master
			if ((grant_q[m] == GRANT_SLAVE) && m_idle[m] && !(m_valid[m] && on_target[m])
					&& slv_wanted[grant_idx_q[m]])
				do_drop[m] = 1'b1;
		end
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			for (int m = 0; m < NUM_MASTERS; m++)
			begin
				grant_q[m]     <= GRANT_NONE;
				grant_idx_q[m] <= '0;
			end
		end
		else
		begin
			for (int m = 0; m < NUM_MASTERS; m++)
			begin
				if (do_switch[m])
				begin
					if (m_is_err[m])
						grant_q[m] <= GRANT_ERROR;
					else
						grant_q[m] <= GRANT_SLAVE;
					grant_idx_q[m] <= m_slv[m];
				end
				else if (do_drop[m])
					grant_q[m] <= GRANT_NONE;
			end
		end
	end

	// error target needs room in the return path, a slave needs a free AR stage
	always_comb
	begin
		for (int m = 0; m < NUM_MASTERS; m++)
		begin
			m_accept[m] = 1'b0;
			if (m_valid[m] && !m_full[m] && on_target[m])
			begin
				if (m_is_err[m])
					m_accept[m] = i_r_take[m];
				else
					m_accept[m] = !o_m_arvalid[m_slv[m]] || i_m_arready[m_slv[m]];
			end
		end
	end

	always_comb
	begin
		for (int s = 0; s < NUM_SLAVES; s++)
		begin
			slv_load[s]   = slv_owned[s] && m_accept[slv_owner[s]]
				&& !m_is_err[slv_owner[s]];
			o_m_rready[s] = slv_owned[s] && i_r_take[slv_owner[s]];
		end
	end

	// registered AR stage per slave
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			o_m_arvalid <= '0;
		else
		begin
			for (int s = 0; s < NUM_SLAVES; s++)
			begin
				if (!o_m_arvalid[s] || i_m_arready[s])
					o_m_arvalid[s] <= slv_load[s];
			end
		end
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		for (int s = 0; s < NUM_SLAVES; s++)
		begin
			if (slv_load[s])
			begin
				o_m_araddr[s] <= m_addr[slv_owner[s]];
				o_m_arprot[s] <= m_prot[slv_owner[s]];
			end
		end
	end

endmodule

//--- hdl/rd_return_path.sv
module rd_return_path (
	input  logic                                                  S_AXI_ACLK,
	input  logic                                                  S_AXI_ARESETN,
	input  xbar_pkg::grant_e                                      i_grant,
	input  logic [xbar_pkg::SLV_IDX_W-1:0]                        i_grant_idx,
	input  logic [xbar_pkg::NUM_SLAVES-1:0]                       i_m_rvalid,
	input  logic [xbar_pkg::NUM_SLAVES-1:0][xbar_pkg::DATA_W-1:0] i_m_rdata,
	input  logic [xbar_pkg::NUM_SLAVES-1:0][xbar_pkg::RESP_W-1:0] i_m_rresp,
	input  logic                                                  i_s_rready,
	output logic                                                  o_r_take,
	output logic                                                  o_s_rvalid,
	output logic [xbar_pkg::DATA_W-1:0]                           o_s_rdata,
	output logic [xbar_pkg::RESP_W-1:0]                           o_s_rresp,
	rd_req_if.monitor                                             req
);
	import xbar_pkg::*;

	logic              err_beat;
	logic              slv_beat;
	logic              in_valid;
	logic [DATA_W-1:0] in_data;
	logic [RESP_W-1:0] in_resp;
	logic              out_stall;
	logic              ovf_valid;
	logic [DATA_W-1:0] ovf_data;
	logic [RESP_W-1:0] ovf_resp;
	logic [PEND_W-1:0] pend;

	// room for one more beat while the overflow slot is empty
	assign o_r_take  = !ovf_valid;
	assign out_stall = o_s_rvalid && !i_s_rready;

	// an accepted unmapped request answers itself
	assign err_beat = req.valid && req.accept && req.is_err;
	assign slv_beat = (i_grant == GRANT_SLAVE) && i_m_rvalid[i_grant_idx] && o_r_take;
	assign in_valid = err_beat || slv_beat;

	always_comb
	begin
		if (err_beat)
		begin
			in_data = '0;
			in_resp = RESP_DECERR;
		end
		else
		begin
			in_data = i_m_rdata[i_grant_idx];
			in_resp = i_m_rresp[i_grant_idx];
		end
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			o_s_rvalid <= 1'b0;
			ovf_valid  <= 1'b0;
		end
		else if (!out_stall)
		begin
			o_s_rvalid <= ovf_valid || in_valid;
			ovf_valid  <= 1'b0;
		end
		else if (in_valid)
			ovf_valid <= 1'b1;
	end

	// overflow slot drains first, it holds the older beat
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!out_stall)
		begin
			if (ovf_valid)
			begin
				o_s_rdata <= ovf_data;
				o_s_rresp <= ovf_resp;
			end
			else if (in_valid)
			begin
				o_s_rdata <= in_data;
				o_s_rresp <= in_resp;
			end
		end
		else if (in_valid)
		begin
			ovf_data <= in_data;
			ovf_resp <= in_resp;
		end
	end

	// reads issued but not yet returned to the master
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			pend <= '0;
		else
		begin
			case ({req.accept, o_s_rvalid && i_s_rready})
				2'b10:   pend <= pend + 1'b1;
				2'b01:   pend <= pend - 1'b1;
				default: pend <= pend;
			endcase
		end
	end

	assign req.idle = (pend == '0);
	assign req.full = &pend;

endmodule

//--- hdl/axil_rd_xbar.sv
module axil_rd_xbar (
	input  logic                                                   S_AXI_ACLK,
	input  logic                                                   S_AXI_ARESETN,
	// toward the masters
	input  logic [xbar_pkg::NUM_MASTERS-1:0]                       i_s_arvalid,
	output logic [xbar_pkg::NUM_MASTERS-1:0]                       o_s_arready,
	input  logic [xbar_pkg::NUM_MASTERS-1:0][xbar_pkg::ADDR_W-1:0] i_s_araddr,
	input  logic [xbar_pkg::NUM_MASTERS-1:0][xbar_pkg::PROT_W-1:0] i_s_arprot,
	output logic [xbar_pkg::NUM_MASTERS-1:0]                       o_s_rvalid,
	input  logic [xbar_pkg::NUM_MASTERS-1:0]                       i_s_rready,
	output logic [xbar_pkg::NUM_MASTERS-1:0][xbar_pkg::DATA_W-1:0] o_s_rdata,
	output logic [xbar_pkg::NUM_MASTERS-1:0][xbar_pkg::RESP_W-1:0] o_s_rresp,
	// toward the slaves
	output logic [xbar_pkg::NUM_SLAVES-1:0]                        o_m_arvalid,
	input  logic [xbar_pkg::NUM_SLAVES-1:0]                        i_m_arready,
	output logic [xbar_pkg::NUM_SLAVES-1:0][xbar_pkg::ADDR_W-1:0]  o_m_araddr,
	output logic [xbar_pkg::NUM_SLAVES-1:0][xbar_pkg::PROT_W-1:0]  o_m_arprot,
	input  logic [xbar_pkg::NUM_SLAVES-1:0]                        i_m_rvalid,
	output logic [xbar_pkg::NUM_SLAVES-1:0]                        o_m_rready,
	input  logic [xbar_pkg::NUM_SLAVES-1:0][xbar_pkg::DATA_W-1:0]  i_m_rdata,
	input  logic [xbar_pkg::NUM_SLAVES-1:0][xbar_pkg::RESP_W-1:0]  i_m_rresp
);
	import xbar_pkg::*;

	grant_e                                grant [NUM_MASTERS];
	logic [NUM_MASTERS-1:0][SLV_IDX_W-1:0] grant_idx;
	logic [NUM_MASTERS-1:0]                r_take;

	rd_req_if req_bus [NUM_MASTERS] ();

	// per master decoder and return path
	for (genvar g = 0; g < NUM_MASTERS; g++)
	begin : g_master
		rd_addr_decode i_decode (
			.S_AXI_ACLK    (S_AXI_ACLK),
			.S_AXI_ARESETN (S_AXI_ARESETN),
			.i_s_arvalid   (i_s_arvalid[g]),
			.o_s_arready   (o_s_arready[g]),
			.i_s_araddr    (i_s_araddr[g]),
			.i_s_arprot    (i_s_arprot[g]),
			.req           (req_bus[g])
		);

		rd_return_path i_return (
			.S_AXI_ACLK    (S_AXI_ACLK),
			.S_AXI_ARESETN (S_AXI_ARESETN),
			.i_grant       (grant[g]),
			.i_grant_idx   (grant_idx[g]),
			.i_m_rvalid    (i_m_rvalid),
			.i_m_rdata     (i_m_rdata),
			.i_m_rresp     (i_m_rresp),
			.i_s_rready    (i_s_rready[g]),
			.o_r_take      (r_take[g]),
			.o_s_rvalid    (o_s_rvalid[g]),
			.o_s_rdata     (o_s_rdata[g]),
			.o_s_rresp     (o_s_rresp[g]),
			.req           (req_bus[g])
		);
	end

	rd_grant_arbiter i_arbiter (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.i_m_arready   (i_m_arready),
		.i_r_take      (r_take),
		.o_m_arvalid   (o_m_arvalid),
		.o_m_araddr    (o_m_araddr),
		.o_m_arprot    (o_m_arprot),
		.o_m_rready    (o_m_rready),
		.o_grant       (grant),
		.o_grant_idx   (grant_idx),
		.req           (req_bus)
	);

endmodule

//--- test/axil_rd_xbar_asserts.sv
module axil_rd_xbar_asserts (
	input logic                                                   S_AXI_ACLK,
	input logic                                                   S_AXI_ARESETN,
	input logic [xbar_pkg::NUM_SLAVES-1:0]                        o_m_arvalid,
	input logic [xbar_pkg::NUM_SLAVES-1:0]                        i_m_arready,
	input logic [xbar_pkg::NUM_SLAVES-1:0][xbar_pkg::ADDR_W-1:0]  o_m_araddr,
	input logic [xbar_pkg::NUM_MASTERS-1:0]                       o_s_rvalid,
	input logic [xbar_pkg::NUM_MASTERS-1:0]                       i_s_rready,
	input logic [xbar_pkg::NUM_MASTERS-1:0][xbar_pkg::DATA_W-1:0] o_s_rdata
);
	timeunit 1ns;
	timeprecision 1ps;
	import xbar_pkg::*;

	int fail_count = 0;

	// AR held toward a stalled slave
	for (genvar s = 0; s < NUM_SLAVES; s++)
	begin : g_slave
		a_ar_stable: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
			o_m_arvalid[s] && !i_m_arready[s] |=> o_m_arvalid[s] && $stable(o_m_araddr[s]))
		else
		begin
			fail_count++;
			$error("AR toward slave %0d changed while stalled", s);
		end
	end

	// R held toward a stalled master
	for (genvar m = 0; m < NUM_MASTERS; m++)
	begin : g_master
		a_r_stable: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
			o_s_rvalid[m] && !i_s_rready[m] |=> o_s_rvalid[m] && $stable(o_s_rdata[m]))
		else
		begin
			fail_count++;
			$error("R toward master %0d changed while stalled", m);
		end
	end

	a_rst_rvalid: assert property (@(posedge S_AXI_ACLK)
		!S_AXI_ARESETN |=> o_s_rvalid == '0)
	else
	begin
		fail_count++;
		$error("R valid high after a reset cycle");
	end

endmodule

//--- test/tb_axil_rd_xbar.sv
module tb_axil_rd_xbar;
	timeunit 1ns;
	timeprecision 1ps;
	import xbar_pkg::*;

	localparam int CLK_PERIOD       = 20;
	localparam int READS_PER_MASTER = 150;
	localparam int WATCHDOG_CYCLES  = NUM_MASTERS * READS_PER_MASTER * 200;
	localparam logic [NUM_SLAVES-1:0][DATA_W-1:0] SLV_SIG = {32'hc3c3_1e1e, 32'h5a5a_0f0f};

	logic                                S_AXI_ACLK;
	logic                                S_AXI_ARESETN;
	logic [NUM_MASTERS-1:0]              s_arvalid;
	logic [NUM_MASTERS-1:0]              s_arready;
	logic [NUM_MASTERS-1:0][ADDR_W-1:0]  s_araddr;
	logic [NUM_MASTERS-1:0][PROT_W-1:0]  s_arprot;
	logic [NUM_MASTERS-1:0]              s_rvalid;
	logic [NUM_MASTERS-1:0]              s_rready;
	logic [NUM_MASTERS-1:0][DATA_W-1:0]  s_rdata;
	logic [NUM_MASTERS-1:0][RESP_W-1:0]  s_rresp;
	logic [NUM_SLAVES-1:0]               m_arvalid;
	logic [NUM_SLAVES-1:0]               m_arready;
	logic [NUM_SLAVES-1:0][ADDR_W-1:0]   m_araddr;
	logic [NUM_SLAVES-1:0][PROT_W-1:0]   m_arprot;
	logic [NUM_SLAVES-1:0]               m_rvalid;
	logic [NUM_SLAVES-1:0]               m_rready;
	logic [NUM_SLAVES-1:0][DATA_W-1:0]   m_rdata;
	logic [NUM_SLAVES-1:0][RESP_W-1:0]   m_rresp;

	logic [31:0]            lfsr_state = 32'h8ba7edc0;
	logic [NUM_MASTERS-1:0] ar_busy;
	logic [NUM_SLAVES-1:0]  r_busy;
	int                     issued [NUM_MASTERS];
	int                     responses;
	int                     errors;

	// expected beats {master, resp, data}, in issue order
	logic [34:0] exp_q [$];
	// issued mapped reads not yet seen at a slave {slave, prot, addr}
	logic [35:0] fwd_q [$];
	// reads a slave model still owes {slave, addr}
	logic [32:0] slv_q [$];

	axil_rd_xbar i_dut (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.i_s_arvalid   (s_arvalid),
		.o_s_arready   (s_arready),
		.i_s_araddr    (s_araddr),
		.i_s_arprot    (s_arprot),
		.o_s_rvalid    (s_rvalid),
		.i_s_rready    (s_rready),
		.o_s_rdata     (s_rdata),
		.o_s_rresp     (s_rresp),
		.o_m_arvalid   (m_arvalid),
		.i_m_arready   (m_arready),
		.o_m_araddr    (m_araddr),
		.o_m_arprot    (m_arprot),
		.i_m_rvalid    (m_rvalid),
		.o_m_rready    (m_rready),
		.i_m_rdata     (m_rdata),
		.i_m_rresp     (m_rresp)
	);

	bind axil_rd_xbar axil_rd_xbar_asserts i_asserts (.*);

	initial
	begin
		S_AXI_ACLK = 1'b0;
		forever #(CLK_PERIOD / 2) S_AXI_ACLK = ~S_AXI_ACLK;
	end

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr_state = lfsr_step(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	// six in eight mapped, the rest split over 10 and 11
	function automatic logic [1:0] pick_window(input logic [2:0] r);
		if (r < 3)
			return 2'b00;
		else if (r < 6)
			return 2'b01;
		return r[1:0];
	endfunction

	// slave 0 at 00, slave 1 at 01, anything else answered by the crossbar
	function automatic logic [RESP_W+DATA_W-1:0] expected_beat(input logic [ADDR_W-1:0] addr);
		case (addr[31:30])
			2'b00:   return {RESP_OKAY, addr ^ SLV_SIG[0]};
			2'b01:   return {RESP_OKAY, addr ^ SLV_SIG[1]};
			default: return {RESP_DECERR, {DATA_W{1'b0}}};
		endcase
	endfunction

	function automatic int first_for_master(input int m);
		for (int i = 0; i < exp_q.size(); i++)
		begin
			if (exp_q[i][34] == 1'(m))
				return i;
		end
		return -1;
	endfunction

	function automatic int first_for_slave(input int s);
		for (int i = 0; i < slv_q.size(); i++)
		begin
			if (slv_q[i][32] == 1'(s))
				return i;
		end
		return -1;
	endfunction

	function automatic int find_forward(input logic [35:0] key);
		for (int i = 0; i < fwd_q.size(); i++)
		begin
			if (fwd_q[i] == key)
				return i;
		end
		return -1;
	endfunction

	function automatic logic all_done();
		return (issued[0] == READS_PER_MASTER) && (issued[1] == READS_PER_MASTER)
			&& (exp_q.size() == 0) && (fwd_q.size() == 0) && (slv_q.size() == 0);
	endfunction

	task automatic drive_inputs();
		int         idx;
		logic       go;
		logic [1:0] win;
		@(negedge S_AXI_ACLK);
		for (int m = 0; m < NUM_MASTERS; m++)
		begin
			go = (rand_bits(2) != 0);
			if (!ar_busy[m])
				s_arvalid[m] = 1'b0;
			if (!ar_busy[m] && go && (issued[m] < READS_PER_MASTER))
			begin
				win          = pick_window(3'(rand_bits(3)));
				s_araddr[m]  = {win, 30'(rand_bits(30))};
				s_arprot[m]  = 3'(rand_bits(3));
				s_arvalid[m] = 1'b1;
				ar_busy[m]   = 1'b1;
			end
			s_rready[m] = (rand_bits(2) != 0);
		end
		// slave models answer in order after a random wait
		for (int s = 0; s < NUM_SLAVES; s++)
		begin
			m_arready[s] = (rand_bits(2) != 0);
			go = (rand_bits(1) != 0);
			if (!r_busy[s])
				m_rvalid[s] = 1'b0;
			idx = first_for_slave(s);
			if (!r_busy[s] && go && (idx >= 0))
			begin
				m_rvalid[s] = 1'b1;
				m_rdata[s]  = slv_q[idx][31:0] ^ SLV_SIG[s];
				m_rresp[s]  = RESP_OKAY;
				r_busy[s]   = 1'b1;
			end
		end
	endtask

	task automatic check_outputs();
		int          idx;
		logic [34:0] beat;
		string       name;
		for (int m = 0; m < NUM_MASTERS; m++)
		begin
			if (s_arvalid[m] && s_arready[m])
			begin
				ar_busy[m] = 1'b0;
				issued[m]++;
				exp_q.push_back({1'(m), expected_beat(s_araddr[m])});
				if (!s_araddr[m][31])
					fwd_q.push_back({s_araddr[m][30], s_arprot[m], s_araddr[m]});
			end
		end
		for (int s = 0; s < NUM_SLAVES; s++)
		begin
			if (m_arvalid[s] && m_arready[s])
			begin
				idx = find_forward({1'(s), m_arprot[s], m_araddr[s]});
				if (idx < 0)
				begin
					errors++;
					$display("slave %0d got an AR no master sent to it: addr %h prot %h",
						s, m_araddr[s], m_arprot[s]);
				end
				else
				begin
					fwd_q.delete(idx);
					slv_q.push_back({1'(s), m_araddr[s]});
				end
			end
			if (m_rvalid[s] && m_rready[s])
			begin
				r_busy[s] = 1'b0;
				slv_q.delete(first_for_slave(s));
			end
		end
		for (int m = 0; m < NUM_MASTERS; m++)
		begin
			if (s_rvalid[m] && s_rready[m])
			begin
				responses++;
				idx = first_for_master(m);
				if (idx < 0)
				begin
					errors++;
					$display("master %0d got an R beat with no read outstanding", m);
				end
				else
				begin
					beat = exp_q[idx];
					name = (beat[33:32] == RESP_DECERR) ? "unmapped_read" : "mapped_read";
					if ({s_rresp[m], s_rdata[m]} != beat[33:0])
					begin
						errors++;
						$display("Mismatch %s master %0d: expected %h actual %h",
							name, m, beat[33:0], {s_rresp[m], s_rdata[m]});
					end
					exp_q.delete(idx);
				end
			end
		end
	endtask

	task automatic print_counts();
		$display("errors %0d, assertion failures %0d, reads issued %0d, responses %0d",
			errors, i_dut.i_asserts.fail_count, issued[0] + issued[1], responses);
	endtask

	initial
	begin
		S_AXI_ARESETN = 1'b0;
		s_arvalid     = '0;
		s_araddr      = '0;
		s_arprot      = '0;
		s_rready      = '0;
		m_arready     = '0;
		m_rvalid      = '0;
		m_rdata       = '0;
		m_rresp       = '0;
		ar_busy       = '0;
		r_busy        = '0;
		issued        = '{default: 0};
		responses     = 0;
		errors        = 0;
		repeat (3) @(posedge S_AXI_ACLK);
		@(negedge S_AXI_ACLK);
		S_AXI_ARESETN = 1'b1;
		while (!all_done())
		begin
			drive_inputs();
			#1;
			check_outputs();
		end
		// idle a while so stray beats show up
		repeat (20)
		begin
			drive_inputs();
			#1;
			check_outputs();
		end
		if (responses != issued[0] + issued[1])
		begin
			errors++;
			$display("response count %0d does not match %0d issued reads",
				responses, issued[0] + issued[1]);
		end
		print_counts();
		if ((errors == 0) && (i_dut.i_asserts.fail_count == 0))
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

	// worst case of 200 cycles per read
	initial
	begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("timeout: reads still outstanding after %0d cycles", WATCHDOG_CYCLES);
		print_counts();
		$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

//--- build.f
hdl/xbar_pkg.sv
hdl/rd_req_if.sv
hdl/rd_addr_decode.sv
hdl/rd_grant_arbiter.sv
hdl/rd_return_path.sv
hdl/axil_rd_xbar.sv
test/axil_rd_xbar_asserts.sv
test/tb_axil_rd_xbar.sv

//--- run_sim.sh
#!/bin/sh
# build and run the read crossbar testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert --timescale 1ns/1ps -j 0 --top-module tb_axil_rd_xbar \
	-f build.f -o tb_axil_rd_xbar \
	&& ./obj_dir/tb_axil_rd_xbar +verilator+error+limit+1000 > sim.log 2>&1 \
	|| echo "build or simulation did not complete" >> sim.log
cat sim.log
grep -q "Simulation finished: FAIL" sim.log && exit 1
grep -q "Simulation finished: PASS" sim.log || exit 1
exit 0
